/* design/cpu_types_pkg.sv */
package cpu_types_pkg;

    localparam int WORD_W = 32;
    localparam int ADDR_W = 16;

    localparam int FLAG_Z = 0;          // Zero flag bit
    localparam int FLAG_C = 1;          // Carry flag bit

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [1:0]        reg_sel_t;
    typedef logic [1:0]        flags_t;

    typedef struct packed {
        logic     en;
        reg_sel_t sel;
        word_t    data;
    } reg_write_t;

    typedef struct packed {
        logic   zero_en;
        logic   carry_en;
        flags_t value;
    } flag_write_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_OR, ALU_AND, ALU_XOR, ALU_NOT, ALU_SHL, ALU_SAR
    } alu_op_t;

    typedef struct packed {
        logic  advance;
        logic  load;                    // Wins over advance
        addr_t target;
    } pc_ctrl_t;

endpackage

/* design/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    typedef logic [7:0] opcode_t;

    ////////////////////////////////////////////////////////////////////////////
    // Opcode fields inside the instruction word
    ////////////////////////////////////////////////////////////////////////////

    localparam int OPC_MSB = 7;
    localparam int OPC_LSB = 0;
    localparam int REG_MSB = 5;         // Register select of LD/ST/INC/DEC
    localparam int REG_LSB = 4;

    localparam cpu_types_pkg::reg_sel_t REG_A    = 2'd0;
    localparam cpu_types_pkg::reg_sel_t REG_X    = 2'd1;
    localparam cpu_types_pkg::reg_sel_t REG_Y    = 2'd2;
    localparam cpu_types_pkg::reg_sel_t REG_NONE = 2'd3;  // Not a register

    localparam cpu_types_pkg::addr_t RESET_PC  = 16'h0000;
    localparam int                   SHIFT_AMT = 1;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////////////////////

    localparam opcode_t OP_NOP = 8'h00;
    localparam opcode_t OP_LDI = 8'h01;     // Base, register in 5:4
    localparam opcode_t OP_LDM = 8'h81;     // Base, indirect
    localparam opcode_t OP_ST  = 8'h03;     // Base
    localparam opcode_t OP_ADD = 8'h08;
    localparam opcode_t OP_SUB = 8'h09;
    localparam opcode_t OP_JMP = 8'h10;
    localparam opcode_t OP_OR  = 8'h30;
    localparam opcode_t OP_AND = 8'h31;
    localparam opcode_t OP_XOR = 8'h32;
    localparam opcode_t OP_NOT = 8'h33;
    localparam opcode_t OP_SHL = 8'h34;
    localparam opcode_t OP_SAR = 8'h35;
    localparam opcode_t OP_BZ  = 8'h36;
    localparam opcode_t OP_BNZ = 8'h37;
    localparam opcode_t OP_BC  = 8'h38;
    localparam opcode_t OP_BCC = 8'h39;
    localparam opcode_t OP_TAX = 8'h40;
    localparam opcode_t OP_TAY = 8'h41;
    localparam opcode_t OP_INC = 8'h48;     // Base
    localparam opcode_t OP_DEC = 8'h49;     // Base
    localparam opcode_t OP_TXA = 8'h50;
    localparam opcode_t OP_TYA = 8'h51;

    typedef enum logic [1:0] {
        FETCH,
        OPERAND,
        DATA
    } ctrl_state_t;

endpackage

/* design/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_types_pkg::alu_op_t op,
    input  cpu_types_pkg::word_t   a,
    input  cpu_types_pkg::word_t   b,
    output cpu_types_pkg::word_t   result,
    output logic                   zero,
    output logic                   carry
);
    import cpu_types_pkg::*;
    import cpu_isa_pkg::*;

    logic  sub;
    logic  cout;
    word_t b_in;
    word_t sum;

    // One adder for both directions, sub is a + ~b + 1
    assign sub         = (op == ALU_SUB);
    assign b_in        = sub ? ~b : b;
    assign {cout, sum} = {1'b0, a} + {1'b0, b_in} + {{WORD_W{1'b0}}, sub};

    always_comb begin
        case (op)
            ALU_ADD, ALU_SUB: result = sum;
            ALU_OR:           result = a | b;
            ALU_AND:          result = a & b;
            ALU_XOR:          result = a ^ b;
            ALU_NOT:          result = ~a;
            ALU_SHL:          result = a << SHIFT_AMT;
            ALU_SAR:          result = word_t'($signed(a) >>> SHIFT_AMT);  // Sign fill
            default:          result = sum;
        endcase
    end

    assign zero  = (result == '0);
    assign carry = (op == ALU_ADD || op == ALU_SUB) ? cout : 1'b0;   // No borrow on sub

endmodule

/* design/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  cpu_types_pkg::pc_ctrl_t ctrl,
    output cpu_types_pkg::addr_t    pc
);
    import cpu_types_pkg::*;
    import cpu_isa_pkg::*;

    addr_t pc_next;

    always_comb begin
        if (ctrl.load) begin
            pc_next = ctrl.target;              // Jump or taken branch
        end else if (ctrl.advance) begin
            pc_next = pc + addr_t'(1);
        end else begin
            pc_next = pc;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

/* design/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                       clk,
    input  logic                       reset,
    input  cpu_types_pkg::reg_write_t  reg_write,
    input  cpu_types_pkg::flag_write_t flag_write,
    output cpu_types_pkg::word_t       a_reg,
    output cpu_types_pkg::word_t       x_reg,
    output cpu_types_pkg::word_t       y_reg,
    output cpu_types_pkg::flags_t      flags
);
    import cpu_types_pkg::*;
    import cpu_isa_pkg::*;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            a_reg <= '0;
            x_reg <= '0;
            y_reg <= '0;
        end else if (reg_write.en) begin
            case (reg_write.sel)
                REG_A:   a_reg <= reg_write.data;
                REG_X:   x_reg <= reg_write.data;
                REG_Y:   y_reg <= reg_write.data;
                default: ;                      // Select 3 writes nothing
            endcase
        end
    end

    // Each flag has its own enable
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags <= '0;
        end else begin
            if (flag_write.zero_en) begin
                flags[FLAG_Z] <= flag_write.value[FLAG_Z];
            end
            if (flag_write.carry_en) begin
                flags[FLAG_C] <= flag_write.value[FLAG_C];
            end
        end
    end

endmodule

/* design/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  cpu_types_pkg::word_t       din,
    input  cpu_types_pkg::addr_t       pc,
    input  cpu_types_pkg::word_t       a_reg,
    input  cpu_types_pkg::word_t       x_reg,
    input  cpu_types_pkg::word_t       y_reg,
    input  cpu_types_pkg::flags_t      flags,
    input  cpu_types_pkg::word_t       alu_result,
    input  logic                       alu_zero,
    input  logic                       alu_carry,
    output cpu_types_pkg::alu_op_t     alu_op,
    output cpu_types_pkg::word_t       alu_a,
    output cpu_types_pkg::word_t       alu_b,
    output cpu_types_pkg::pc_ctrl_t    pc_ctrl,
    output cpu_types_pkg::reg_write_t  reg_write,
    output cpu_types_pkg::flag_write_t flag_write,
    output cpu_types_pkg::addr_t       addr,
    output cpu_types_pkg::word_t       dout,
    output logic                       rw
);
    import cpu_types_pkg::*;
    import cpu_isa_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    opcode_t     ir;            // Instruction register
    addr_t       ab;            // Address buffer
    word_t       sd;            // Store data
    opcode_t     base_op;       // Opcode with register field cleared
    reg_sel_t    sel;
    word_t       sel_reg;
    alu_op_t     ir_alu_op;
    logic        is_ldi;
    logic        is_ldm;
    logic        is_st;
    logic        is_inc;
    logic        is_dec;
    logic        taken;

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    assign sel     = ir[REG_MSB:REG_LSB];
    assign base_op = {ir[OPC_MSB:REG_MSB+1], 2'b00, ir[REG_LSB-1:OPC_LSB]};
    assign is_ldi  = (sel != REG_NONE) && (base_op == OP_LDI);
    assign is_ldm  = (sel != REG_NONE) && (base_op == OP_LDM);
    assign is_st   = (sel != REG_NONE) && (base_op == OP_ST);
    assign is_inc  = (sel != REG_NONE) && (base_op == OP_INC);
    assign is_dec  = (sel != REG_NONE) && (base_op == OP_DEC);

    always_comb begin
        case (sel)
            REG_X:   sel_reg = x_reg;
            REG_Y:   sel_reg = y_reg;
            default: sel_reg = a_reg;
        endcase
    end

    always_comb begin
        case (ir)
            OP_SUB:  ir_alu_op = ALU_SUB;
            OP_OR:   ir_alu_op = ALU_OR;
            OP_AND:  ir_alu_op = ALU_AND;
            OP_XOR:  ir_alu_op = ALU_XOR;
            OP_NOT:  ir_alu_op = ALU_NOT;
            OP_SHL:  ir_alu_op = ALU_SHL;
            OP_SAR:  ir_alu_op = ALU_SAR;
            default: ir_alu_op = ALU_ADD;
        endcase
    end

    // The only place branch conditions are tested
    always_comb begin
        case (ir)
            OP_BZ:   taken = flags[FLAG_Z];
            OP_BNZ:  taken = !flags[FLAG_Z];
            OP_BC:   taken = flags[FLAG_C];
            OP_BCC:  taken = !flags[FLAG_C];
            default: taken = 1'b1;              // JMP
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // FSM outputs
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next               = state;
        alu_op                   = ALU_ADD;
        alu_a                    = a_reg;
        alu_b                    = din;
        pc_ctrl                  = '0;
        pc_ctrl.target           = din[ADDR_W-1:0];
        reg_write                = '0;
        reg_write.sel            = REG_A;
        reg_write.data           = alu_result;
        flag_write               = '0;
        flag_write.value[FLAG_Z] = alu_zero;
        flag_write.value[FLAG_C] = alu_carry;
        case (state)
            FETCH: begin
                pc_ctrl.advance = 1'b1;
                state_next      = OPERAND;
            end
            OPERAND: begin
                state_next = FETCH;
                if (is_ldi) begin
                    alu_op             = ALU_OR;        // 0 | din, for the zero flag
                    alu_a              = '0;
                    reg_write.en       = 1'b1;
                    reg_write.sel      = sel;
                    flag_write.zero_en = 1'b1;
                    pc_ctrl.advance    = 1'b1;
                end else if (is_ldm || is_st) begin
                    pc_ctrl.advance = 1'b1;             // Address word consumed
                    state_next      = DATA;
                end else if (is_inc || is_dec) begin
                    alu_op              = is_dec ? ALU_SUB : ALU_ADD;
                    alu_a               = sel_reg;
                    alu_b               = word_t'(1);
                    reg_write.en        = 1'b1;
                    reg_write.sel       = sel;
                    flag_write.zero_en  = 1'b1;
                    flag_write.carry_en = 1'b1;
                end else begin
                    case (ir)
                        OP_ADD, OP_SUB, OP_OR, OP_AND, OP_XOR: begin
                            alu_op              = ir_alu_op;
                            reg_write.en        = 1'b1;
                            flag_write.zero_en  = 1'b1;
                            flag_write.carry_en = (ir == OP_ADD) || (ir == OP_SUB);
                            pc_ctrl.advance     = 1'b1;
                        end
                        OP_NOT, OP_SHL, OP_SAR: begin
                            alu_op             = ir_alu_op;
                            reg_write.en       = 1'b1;
                            flag_write.zero_en = 1'b1;
                        end
                        OP_TAX, OP_TAY: begin
                            reg_write.en   = 1'b1;
                            reg_write.sel  = (ir == OP_TAX) ? REG_X : REG_Y;
                            reg_write.data = a_reg;
                        end
                        OP_TXA, OP_TYA: begin
                            reg_write.en   = 1'b1;
                            reg_write.data = (ir == OP_TXA) ? x_reg : y_reg;
                        end
                        OP_JMP, OP_BZ, OP_BNZ, OP_BC, OP_BCC: begin
                            pc_ctrl.load    = taken;
                            pc_ctrl.advance = !taken;   // Skip the target word
                        end
                        default: ;                      // NOP and unknown opcodes
                    endcase
                end
            end
            DATA: begin
                state_next = FETCH;
                if (is_ldm) begin
                    alu_op             = ALU_OR;
                    alu_a              = '0;
                    reg_write.en       = 1'b1;
                    reg_write.sel      = sel;
                    flag_write.zero_en = 1'b1;
                end
            end
            default: state_next = FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
            ir    <= OP_NOP;
        end else begin
            state <= state_next;
            if (state == FETCH) begin
                ir <= din[OPC_MSB:OPC_LSB];
            end
        end
    end

    // Indirect address and store data, taken in OPERAND
    always_ff @(posedge clk) begin
        if (state == OPERAND && (is_ldm || is_st)) begin
            ab <= din[ADDR_W-1:0];
            sd <= sel_reg;
        end
    end

    assign addr = (state == DATA) ? ab : pc;
    assign dout = sd;
    assign rw   = !((state == DATA) && is_st);  // Low only in a store's DATA cycle

endmodule

/* design/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
    input  logic                 clk,
    input  logic                 reset,
    input  cpu_types_pkg::word_t din,
    output cpu_types_pkg::addr_t addr,
    output cpu_types_pkg::word_t dout,
    output logic                 rw             // High for read
);

    cpu_types_pkg::alu_op_t     alu_op;
    cpu_types_pkg::word_t       alu_a;
    cpu_types_pkg::word_t       alu_b;
    cpu_types_pkg::word_t       alu_result;
    logic                       alu_zero;
    logic                       alu_carry;
    cpu_types_pkg::pc_ctrl_t    pc_ctrl;
    cpu_types_pkg::addr_t       pc;
    cpu_types_pkg::reg_write_t  reg_write;
    cpu_types_pkg::flag_write_t flag_write;
    cpu_types_pkg::word_t       a_reg;
    cpu_types_pkg::word_t       x_reg;
    cpu_types_pkg::word_t       y_reg;
    cpu_types_pkg::flags_t      flags;

    alu i_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero),
        .carry  (alu_carry)
    );

    pc_unit i_pc_unit (
        .clk   (clk),
        .reset (reset),
        .ctrl  (pc_ctrl),
        .pc    (pc)
    );

    register_file i_register_file (
        .clk        (clk),
        .reset      (reset),
        .reg_write  (reg_write),
        .flag_write (flag_write),
        .a_reg      (a_reg),
        .x_reg      (x_reg),
        .y_reg      (y_reg),
        .flags      (flags)
    );

    control_unit i_control_unit (
        .clk        (clk),
        .reset      (reset),
        .din        (din),
        .pc         (pc),
        .a_reg      (a_reg),
        .x_reg      (x_reg),
        .y_reg      (y_reg),
        .flags      (flags),
        .alu_result (alu_result),
        .alu_zero   (alu_zero),
        .alu_carry  (alu_carry),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .pc_ctrl    (pc_ctrl),
        .reg_write  (reg_write),
        .flag_write (flag_write),
        .addr       (addr),
        .dout       (dout),
        .rw         (rw)
    );

endmodule

/* tests/cpu_props.sv */
`timescale 1ns/1ps

module cpu_props (
    input logic                 clk,
    input logic                 reset,
    input cpu_types_pkg::addr_t addr,
    input logic                 rw
);

    // Bus stays in read while held and on release
    a_rw_in_reset: assert property (@(posedge clk) reset |-> rw)
        else $error("rw low while reset is asserted");

    a_rw_after_reset: assert property (@(posedge clk) $fell(reset) |-> rw)
        else $error("rw low in the first cycle after reset");

    a_addr_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(addr))
        else $error("addr has unknown bits");

    // A store has a single DATA cycle
    a_single_write: assert property (@(posedge clk) disable iff (reset) !rw |=> rw)
        else $error("rw low on two consecutive cycles");

endmodule

bind cpu_top cpu_props i_props (
    .clk   (clk),
    .reset (reset),
    .addr  (addr),
    .rw    (rw)
);

/* tests/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
    import cpu_types_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 5;
    localparam int MAX_CYCLES      = 40;      // Per program, until the first store
    localparam int WATCHDOG_CYCLES = 45;
    localparam int MEM_DEPTH       = 256;
    localparam int MEM_AW          = 8;
    localparam int PROG_LEN        = 12;
    localparam int PROG_W          = $clog2(PROG_LEN);
    localparam int N_ENTRIES       = 10;
    localparam int ENTRY_W         = $clog2(N_ENTRIES);
    localparam logic [31:0] SEED   = 32'h4a52;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction words
    ////////////////////////////////////////////////////////////////////////////

    localparam word_t NOP    = 32'h00;
    localparam word_t LDI_A  = 32'h01;
    localparam word_t LDI_Y  = 32'h21;
    localparam word_t LDM_X  = 32'h91;
    localparam word_t LDM_Y  = 32'hA1;
    localparam word_t ST_A   = 32'h03;
    localparam word_t ST_X   = 32'h13;
    localparam word_t ST_Y   = 32'h23;
    localparam word_t ADD_I  = 32'h08;
    localparam word_t SUB_I  = 32'h09;
    localparam word_t JMP    = 32'h10;
    localparam word_t OR_I   = 32'h30;
    localparam word_t AND_I  = 32'h31;
    localparam word_t XOR_I  = 32'h32;
    localparam word_t NOT_A  = 32'h33;
    localparam word_t SHL_A  = 32'h34;
    localparam word_t SAR_A  = 32'h35;
    localparam word_t BZ     = 32'h36;
    localparam word_t BC     = 32'h38;
    localparam word_t BCC    = 32'h39;
    localparam word_t TAX    = 32'h40;
    localparam word_t INC_X  = 32'h58;
    localparam word_t DEC_X  = 32'h59;
    localparam word_t DEC_Y  = 32'h69;
    localparam word_t TYA    = 32'h51;
    localparam word_t BAD_OP = 32'h7F;        // Not in the opcode map

    typedef struct packed {
        addr_t addr;
        word_t data;
    } store_t;

    logic   clk;
    logic   reset;
    word_t  din;
    addr_t  addr;
    word_t  dout;
    logic   rw;

    word_t  mem [MEM_DEPTH];
    word_t  random_fill [MEM_DEPTH];
    word_t  cur_prog [PROG_LEN];
    store_t last_store;
    int     write_count;
    int     error_count;

    string  test_name [N_ENTRIES];
    word_t  prog [N_ENTRIES][PROG_LEN];
    store_t expected [N_ENTRIES];

    cpu_top i_dut (
        .clk   (clk),
        .reset (reset),
        .din   (din),
        .addr  (addr),
        .dout  (dout),
        .rw    (rw)
    );

    assign din = mem[addr[MEM_AW-1:0]];        // Combinational read

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        write_count = 0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[MEM_AW'(i)] = '0;
        end
        forever begin
            @(posedge clk);
            if (reset) begin
                for (int i = 0; i < MEM_DEPTH; i++) begin
                    mem[MEM_AW'(i)] = random_fill[MEM_AW'(i)];
                end
                for (int i = 0; i < PROG_LEN; i++) begin
                    mem[MEM_AW'(i)] = cur_prog[PROG_W'(i)];  // Program over the fill
                end
            end else if (!rw) begin
                mem[addr[MEM_AW-1:0]] <= dout;
                last_store            <= '{addr, dout};
                write_count           <= write_count + 1;
            end
        end
    end

    task automatic build_table();
        test_name[0] = "ldi_a";
        prog[0]      = '{LDI_A, 32'h12345678, ST_A, 32'h000000C0, NOP, NOP,
                         NOP, NOP, NOP, NOP, NOP, NOP};
        expected[0]  = '{16'h00C0, 32'h12345678};
        test_name[1] = "ldm_x";
        prog[1]      = '{LDM_X, 32'h0000000A, ST_X, 32'h000000C1, NOP, NOP,
                         NOP, NOP, NOP, NOP, 32'h5A5A0001, NOP};
        expected[1]  = '{16'h00C1, 32'h5A5A0001};
        test_name[2] = "ldi_y";
        prog[2]      = '{LDI_Y, 32'h11111111, ST_Y, 32'h000000C2, NOP, NOP,
                         NOP, NOP, NOP, NOP, NOP, NOP};
        expected[2]  = '{16'h00C2, 32'h11111111};
        test_name[3] = "add_wrap_bc";
        prog[3]      = '{LDI_A, 32'hFFFFFFF0, ADD_I, 32'h00000020, BC, 32'h00000008,
                         ST_A, 32'h000000C4, ST_A, 32'h000000C5, NOP, NOP};
        expected[3]  = '{16'h00C5, 32'h00000010};   // Carry out, branch taken
        test_name[4] = "sub_bcc";
        prog[4]      = '{LDI_A, 32'h00000005, SUB_I, 32'h00000003, BCC, 32'h00000008,
                         ST_A, 32'h000000C6, ST_A, 32'h000000C7, NOP, NOP};
        expected[4]  = '{16'h00C6, 32'h00000002};   // No borrow, falls through
        test_name[5] = "logic_chain";
        prog[5]      = '{OR_I, 32'h0F0F00F1, AND_I, 32'hF0FF0FF0, XOR_I, 32'h8000FFFF,
                         NOT_A, SHL_A, SAR_A, ST_A, 32'h000000C8, NOP};
        expected[5]  = '{16'h00C8, 32'hFFF000F0};
        test_name[6] = "inc_dec_bz";
        prog[6]      = '{LDI_A, 32'h00000001, TAX, INC_X, DEC_X, DEC_X,
                         BZ, 32'h0000000A, ST_X, 32'h000000CA, ST_X, 32'h000000C9};
        expected[6]  = '{16'h00C9, 32'h00000000};
        test_name[7] = "dec_zero_bcc";
        prog[7]      = '{SUB_I, 32'h00000000, DEC_Y, TYA, BCC, 32'h00000008,
                         ST_A, 32'h000000CB, ST_A, 32'h000000CC, NOP, NOP};
        expected[7]  = '{16'h00CC, 32'hFFFFFFFF};   // Borrow clears carry
        test_name[8] = "jmp_skip";
        prog[8]      = '{JMP, 32'h00000005, ST_A, 32'h000000CD, NOP, BAD_OP,
                         LDI_A, 32'hA5A5A5A5, ST_A, 32'h000000CE, NOP, NOP};
        expected[8]  = '{16'h00CE, 32'hA5A5A5A5};
        test_name[9] = "ldm_y";
        prog[9]      = '{LDM_Y, 32'h0000000B, ST_Y, 32'h000000C3, NOP, NOP,
                         NOP, NOP, NOP, NOP, NOP, 32'hCAFEF00D};
        expected[9]  = '{16'h00C3, 32'hCAFEF00D};
    endtask

    task automatic check_value(input string name, input string field,
                               input word_t expected_value, input word_t actual_value);
        if (expected_value !== actual_value) begin
            error_count++;
            $display("[FAIL] %s %s: expected %h, actual %h",
                     name, field, expected_value, actual_value);
            $display("Test failed");
            $fatal(1, "Mismatch in program %s", name);
        end
    endtask

    task automatic run_program(input int k);
        int     start_count;
        int     cycles;
        store_t exp_store;
        string  name;
        exp_store = expected[ENTRY_W'(k)];
        name      = test_name[ENTRY_W'(k)];
        cur_prog  = prog[ENTRY_W'(k)];
        @(posedge clk);
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        start_count = write_count;
        cycles      = 0;
        while (write_count == start_count && cycles < MAX_CYCLES) begin
            @(negedge clk);                        // Bus results settled here
            cycles++;
        end
        if (write_count == start_count) begin
            $display("Program %s made no store within %0d cycles", name, MAX_CYCLES);
            $display("Test failed");
            $fatal(1, "Missing store in program %s", name);
        end
        check_value(name, "store address", word_t'(exp_store.addr),
                    word_t'(last_store.addr));
        check_value(name, "store data", exp_store.data, last_store.data);
    endtask

    initial begin
        reset       = 1'b1;
        error_count = 0;
        void'($urandom(SEED));
        for (int i = 0; i < MEM_DEPTH; i++) begin
            random_fill[MEM_AW'(i)] = $urandom;
        end
        build_table();
        for (int k = 0; k < N_ENTRIES; k++) begin
            run_program(k);
        end
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(N_ENTRIES * WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all programs finished");
        $display("Test failed");
        $fatal(1, "Simulation timeout");
    end

endmodule

/* flist.f */
design/cpu_types_pkg.sv
design/cpu_isa_pkg.sv
design/alu.sv
design/pc_unit.sv
design/register_file.sv
design/control_unit.sv
design/cpu_top.sv
tests/cpu_props.sv
tests/cpu_tb.sv

/* Makefile */
# Verilator build and run for the accumulator CPU

VERILATOR ?= verilator
TOP       ?= cpu_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only if the simulation printed the pass message
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

clean:
	rm -rf $(OBJ_DIR)
